// File: files.f
+incdir+include
rtl/cu_control_pkg.sv
rtl/cu_input_stage.sv
rtl/cu_read_command_arbiter.sv
rtl/cu_command_buffer.sv
rtl/cu_response_router.sv
rtl/cu_arbiter_control.sv
testbench/tb_clock_gen.sv
testbench/cu_control_assertions.sv
testbench/tb_cu_arbiter_control.sv

// File: include/cu_control_settings.svh
//////////////////////////////
// CU control settings
// CU count, field widths and burst buffer sizing
//////////////////////////////

`ifndef CU_CONTROL_SETTINGS_SVH
`define CU_CONTROL_SETTINGS_SVH

`define NUM_CU 4
`define CU_ID_BITS 2
`define ADDR_BITS 32
`define TAG_BITS 8
`define COUNT_BITS 16

// Burst command FIFO
`define CMD_BUFFER_DEPTH 8
`define CMD_BUFFER_MARGIN 2

// Lower 32 bits carry the active CU count
`define CFG_BITS 64

`endif

// File: rtl/cu_arbiter_control.sv
//////////////////////////////
// CU arbiter control top
// Input stage, read path and response path
//////////////////////////////

`timescale 1ns/10ps
`include "cu_control_settings.svh"

module cu_arbiter_control import cu_control_pkg::*; (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled_in,
	input  logic [`CFG_BITS-1:0] cu_configure,
	input  read_command_t        read_command_cu_in [`NUM_CU],
	input  cu_mask_t             request_read_command_cu_in,
	input  logic                 command_bus_grant,
	input  logic                 host_alfull,
	input  response_t            read_response_in,
	input  count_t               vertex_count_cu_in [`NUM_CU],
	input  count_t               edge_count_cu_in [`NUM_CU],
	output cu_mask_t             enable_cu_out,
	output cu_mask_t             ready_read_command_cu_out,
	output logic                 command_bus_request,
	output read_command_t        read_command_out,
	output response_t            read_response_cu_out [`NUM_CU],
	output count_t               vertex_done_out,
	output count_t               edge_done_out
);

	logic          enabled;
	logic          grant_reg;
	logic          host_alfull_reg;
	logic          buffer_alfull;
	response_t     response_reg;
	read_command_t granted_command;
	count_t        vertex_count_cu [`NUM_CU];
	count_t        edge_count_cu [`NUM_CU];

	cu_input_stage input_stage (
		.clock(clock), .rstn(rstn), .enabled_in(enabled_in),
		.cu_configure(cu_configure), .command_bus_grant(command_bus_grant),
		.host_alfull(host_alfull), .read_response_in(read_response_in),
		.vertex_count_cu_in(vertex_count_cu_in), .edge_count_cu_in(edge_count_cu_in),
		.enabled(enabled), .enable_cu(enable_cu_out), .grant_reg(grant_reg),
		.host_alfull_reg(host_alfull_reg), .response_reg(response_reg),
		.vertex_count_cu(vertex_count_cu), .edge_count_cu(edge_count_cu)
	);

	//////////////////////////////
	// Read command path
	//////////////////////////////

	cu_read_command_arbiter read_arbiter (
		.clock(clock), .rstn(rstn), .enabled(enabled),
		.read_command_cu(read_command_cu_in), .request_cu(request_read_command_cu_in),
		.buffer_alfull(buffer_alfull), .ready_cu(ready_read_command_cu_out),
		.granted_command(granted_command)
	);

	cu_command_buffer command_buffer (
		.clock(clock), .rstn(rstn), .enabled(enabled),
		.granted_command(granted_command), .grant_reg(grant_reg),
		.host_alfull_reg(host_alfull_reg), .buffer_alfull(buffer_alfull),
		.command_bus_request(command_bus_request), .read_command_out(read_command_out)
	);

	cu_response_router response_router (
		.clock(clock), .rstn(rstn), .enabled(enabled), .response_reg(response_reg),
		.vertex_count_cu(vertex_count_cu), .edge_count_cu(edge_count_cu),
		.read_response_cu_out(read_response_cu_out),
		.vertex_done_out(vertex_done_out), .edge_done_out(edge_done_out)
	);

endmodule

// File: rtl/cu_command_buffer.sv
//////////////////////////////
// Burst read command buffer
// FIFO of granted commands, memory bus request and issue
//////////////////////////////

`timescale 1ns/10ps
`include "cu_control_settings.svh"

module cu_command_buffer import cu_control_pkg::*; (
	input  logic          clock,
	input  logic          rstn,
	input  logic          enabled,
	input  read_command_t granted_command,
	input  logic          grant_reg,
	input  logic          host_alfull_reg,
	output logic          buffer_alfull,
	output logic          command_bus_request,
	output read_command_t read_command_out
);

	localparam int PTR_BITS   = $clog2(`CMD_BUFFER_DEPTH);
	localparam int COUNT_BITS = $clog2(`CMD_BUFFER_DEPTH + 1);

	read_command_t         mem [`CMD_BUFFER_DEPTH];
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic [COUNT_BITS-1:0] count_next;
	logic                  push;
	logic                  pop;

	assign push = granted_command.valid && (count != COUNT_BITS'(`CMD_BUFFER_DEPTH));
	// Stray grants on an empty buffer are dropped
	assign pop  = enabled && grant_reg && (count != '0);

	assign count_next = count + COUNT_BITS'(push) - COUNT_BITS'(pop);

	// Counts the push already in flight from the arbiter
	assign buffer_alfull = (int'(count) + int'(granted_command.valid))
		>= (`CMD_BUFFER_DEPTH - `CMD_BUFFER_MARGIN);

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= granted_command;
		end
	end

	//////////////////////////////
	// Pointers and occupancy
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(`CMD_BUFFER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(`CMD_BUFFER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count_next;
		end
	end

	//////////////////////////////
	// Bus side
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_bus_request <= 1'b0;
			read_command_out    <= '0;
		end else begin
			command_bus_request <= enabled && (count_next != '0) && !host_alfull_reg;
			read_command_out    <= '0;
			if (pop) begin
				read_command_out <= mem[rd_ptr];
			end
		end
	end

endmodule

// File: rtl/cu_control_pkg.sv
//////////////////////////////
// CU control types
// Read command, response and opcode definitions
//////////////////////////////

`include "cu_control_settings.svh"

package cu_control_pkg;

	typedef enum logic [1:0] {
		op_read_vertex,
		op_read_edge,
		op_read_prefetch
	} read_op_t;

	typedef struct packed {
		logic                   valid;
		read_op_t               op;
		logic [`CU_ID_BITS-1:0] cu_id;
		logic [`ADDR_BITS-1:0]  address;
	} read_command_t;

	typedef struct packed {
		logic                   valid;
		logic [`CU_ID_BITS-1:0] cu_id;
		logic [`TAG_BITS-1:0]   tag;
	} response_t;

	typedef logic [`NUM_CU-1:0] cu_mask_t;
	typedef logic [`COUNT_BITS-1:0] count_t;

endpackage

// File: rtl/cu_input_stage.sv
//////////////////////////////
// CU input stage
// Registers external inputs and builds the CU enable mask
//////////////////////////////

`timescale 1ns/10ps
`include "cu_control_settings.svh"

module cu_input_stage import cu_control_pkg::*; (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled_in,
	input  logic [`CFG_BITS-1:0] cu_configure,
	input  logic                 command_bus_grant,
	input  logic                 host_alfull,
	input  response_t            read_response_in,
	input  count_t               vertex_count_cu_in [`NUM_CU],
	input  count_t               edge_count_cu_in [`NUM_CU],
	output logic                 enabled,
	output cu_mask_t             enable_cu,
	output logic                 grant_reg,
	output logic                 host_alfull_reg,
	output response_t            response_reg,
	output count_t               vertex_count_cu [`NUM_CU],
	output count_t               edge_count_cu [`NUM_CU]
);

	logic [`CFG_BITS-1:0] cu_configure_latched;
	cu_mask_t             enable_next;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	//////////////////////////////
	// Input capture
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_reg            <= 1'b0;
			host_alfull_reg      <= 1'b0;
			response_reg         <= '0;
			vertex_count_cu      <= '{default: '0};
			edge_count_cu        <= '{default: '0};
			cu_configure_latched <= '0;
		end else if (enabled) begin
			grant_reg       <= command_bus_grant;
			host_alfull_reg <= host_alfull;
			response_reg    <= read_response_in;
			vertex_count_cu <= vertex_count_cu_in;
			edge_count_cu   <= edge_count_cu_in;
			// Zero word keeps the previous setup
			if (|cu_configure) begin
				cu_configure_latched <= cu_configure;
			end
		end
	end

	//////////////////////////////
	// Enable mask
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < `NUM_CU; i++) begin
			enable_next[i] = (i < cu_configure_latched[31:0]);
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable_cu <= '0;
		end else if (enabled) begin
			enable_cu <= enable_next;
		end
	end

endmodule

// File: rtl/cu_read_command_arbiter.sv
//////////////////////////////
// CU read command arbiter
// Round-robin pick of one CU read command per cycle
//////////////////////////////

`timescale 1ns/10ps
`include "cu_control_settings.svh"

module cu_read_command_arbiter import cu_control_pkg::*; (
	input  logic          clock,
	input  logic          rstn,
	input  logic          enabled,
	input  read_command_t read_command_cu [`NUM_CU],
	input  cu_mask_t      request_cu,
	input  logic          buffer_alfull,
	output cu_mask_t      ready_cu,
	output read_command_t granted_command
);

	logic [`CU_ID_BITS-1:0] pointer;
	logic [`CU_ID_BITS-1:0] sel_id;
	cu_mask_t               eligible;
	logic                   grant_valid;

	// A CU seeing ready this cycle still shows its old request
	assign eligible = request_cu & ~ready_cu;

	//////////////////////////////
	// Priority search
	//////////////////////////////

	always_comb begin
		int   idx;
		logic found;
		found  = 1'b0;
		sel_id = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			idx = (int'(pointer) + i) % `NUM_CU;
			if (!found && eligible[idx]) begin
				found  = 1'b1;
				sel_id = `CU_ID_BITS'(idx);
			end
		end
		grant_valid = found && enabled && !buffer_alfull;
	end

	//////////////////////////////
	// Registered grant
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pointer         <= '0;
			ready_cu        <= '0;
			granted_command <= '0;
		end else begin
			ready_cu        <= '0;
			granted_command <= '0;
			if (grant_valid) begin
				ready_cu[sel_id]      <= 1'b1;
				granted_command       <= read_command_cu[sel_id];
				granted_command.valid <= 1'b1;
				// Next search starts just past the winner
				if (sel_id == `CU_ID_BITS'(`NUM_CU - 1)) begin
					pointer <= '0;
				end else begin
					pointer <= sel_id + 1'b1;
				end
			end
		end
	end

endmodule

// File: rtl/cu_response_router.sv
//////////////////////////////
// CU response router
// Routes read responses by CU id, sums done counts
//////////////////////////////

`timescale 1ns/10ps
`include "cu_control_settings.svh"

module cu_response_router import cu_control_pkg::*; (
	input  logic      clock,
	input  logic      rstn,
	input  logic      enabled,
	input  response_t response_reg,
	input  count_t    vertex_count_cu [`NUM_CU],
	input  count_t    edge_count_cu [`NUM_CU],
	output response_t read_response_cu_out [`NUM_CU],
	output count_t    vertex_done_out,
	output count_t    edge_done_out
);

	count_t vertex_sum;
	count_t edge_sum;

	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			vertex_sum = vertex_sum + vertex_count_cu[i];
			edge_sum   = edge_sum + edge_count_cu[i];
		end
	end

	//////////////////////////////
	// Per-CU demux
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_response_cu_out <= '{default: '0};
			vertex_done_out      <= '0;
			edge_done_out        <= '0;
		end else begin
			for (int k = 0; k < `NUM_CU; k++) begin
				// Only the addressed entry carries valid
				if (enabled && response_reg.valid
						&& (response_reg.cu_id == `CU_ID_BITS'(k))) begin
					read_response_cu_out[k] <= response_reg;
				end else begin
					read_response_cu_out[k] <= '0;
				end
			end
			if (enabled) begin
				vertex_done_out <= vertex_sum;
				edge_done_out   <= edge_sum;
			end
		end
	end

endmodule

// File: run_sim.sh
#!/bin/bash
# Build with Verilator, run, then scan the log for the fail message
set -o pipefail

verilator --binary --assert --timescale 1ns/10ps --top-module tb_cu_arbiter_control \
	-f files.f -o tb_sim \
	|| { echo "Build failed"; exit 1; }

./obj_dir/tb_sim 2>&1 | tee sim.log \
	|| { echo "Simulation stopped with an error"; exit 1; }

grep -q "Checks failed" sim.log \
	&& { echo "Result: FAIL"; exit 1; } \
	|| { echo "Result: PASS"; exit 0; }

// File: testbench/cu_control_assertions.sv
//////////////////////////////
// CU control assertions
// Ready, bus request and response routing properties
//////////////////////////////

`timescale 1ns/10ps
`include "cu_control_settings.svh"

module cu_control_assertions import cu_control_pkg::*; (
	input logic      clock,
	input logic      rstn,
	input cu_mask_t  ready,
	input logic      bus_request,
	input logic      host_alfull_reg,
	input response_t responses [`NUM_CU]
);

	assert property (@(posedge clock) disable iff (!rstn) $onehot0(ready))
		else $error("Ready has more than one bit set");

	assert property (@(posedge clock) disable iff (!rstn) (ready & $past(ready)) == '0)
		else $error("Same CU granted in two consecutive cycles");

	// Request register lags the host status by one cycle
	assert property (@(posedge clock) disable iff (!rstn) $past(host_alfull_reg) |-> !bus_request)
		else $error("Bus request while the host is almost full");

	for (genvar k = 0; k < `NUM_CU; k++) begin : g_route
		assert property (@(posedge clock) disable iff (!rstn)
				responses[k].valid |-> responses[k].cu_id == `CU_ID_BITS'(k))
			else $error("Response entry %0d carries another CU id", k);
	end

endmodule

bind cu_arbiter_control cu_control_assertions assertions (
	.clock(clock), .rstn(rstn), .ready(ready_read_command_cu_out),
	.bus_request(command_bus_request), .host_alfull_reg(host_alfull_reg),
	.responses(read_response_cu_out)
);

// File: testbench/tb_clock_gen.sv
//////////////////////////////
// Testbench clock and reset
// 8 ns clock, reset low for 4 cycles
//////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		rstn = 1'b0;
		repeat (4) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

// File: testbench/tb_cu_arbiter_control.sv
//////////////////////////////
// CU arbiter control testbench
// Table-driven stimulus, per-CU command scoreboard
//////////////////////////////

`timescale 1ns/10ps
`include "cu_control_settings.svh"

module tb_cu_arbiter_control import cu_control_pkg::*; ();

	localparam int num_rows = 8;
	localparam response_t no_response = '0;

	typedef struct packed {
		logic [7:0]           cycles;
		logic [`CFG_BITS-1:0] cfg;
		cu_mask_t             req;
		read_op_t             op;
		logic                 grant_en;
		logic                 alfull;
		response_t            resp;
		count_t               vertex_base;
		count_t               edge_base;
		cu_mask_t             exp_mask;
	} row_t;

	logic                 clock;
	logic                 rstn;
	logic                 enabled_in;
	logic [`CFG_BITS-1:0] cu_configure;
	read_command_t        read_command_cu_in [`NUM_CU] = '{default: '0};
	cu_mask_t             request_read_command_cu_in = '0;
	logic                 command_bus_grant = 1'b0;
	logic                 host_alfull;
	response_t            read_response_in;
	count_t               vertex_count_cu_in [`NUM_CU];
	count_t               edge_count_cu_in [`NUM_CU];
	cu_mask_t             enable_cu_out;
	cu_mask_t             ready_read_command_cu_out;
	logic                 command_bus_request;
	read_command_t        read_command_out;
	response_t            read_response_cu_out [`NUM_CU];
	count_t               vertex_done_out;
	count_t               edge_done_out;

	row_t          rows [num_rows];
	string         names [num_rows];
	string         current_test = "reset";
	read_command_t pending_q [`NUM_CU][$];
	read_command_t expect_q [`NUM_CU][$];
	read_command_t cmd_hold [`NUM_CU] = '{default: '0};
	cu_mask_t      req_hold = '0;
	cu_mask_t      ready_seen = '0;
	logic          request_seen = 1'b0;
	logic          grant_pulse = 1'b0;
	logic          bus_grant_enable = 1'b0;
	logic          hold_active = 1'b0;
	int            seed = 48978;
	int            created = 0;
	int            issued = 0;
	int            accepted = 0;
	int            check_errors = 0;
	int            scoreboard_errors = 0;
	int            cycle_count = 0;
	int            cycle_limit = 1000;

	tb_clock_gen clock_gen (.clock(clock), .rstn(rstn));

	cu_arbiter_control uut (.*);

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_mask(input string name, input cu_mask_t expected,
		input cu_mask_t actual, inout int error_count);
		if (actual !== expected) begin
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_command(input string name, input read_command_t expected,
		input read_command_t actual, inout int error_count);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	// A not-valid expectation looks at the valid bit only
	task automatic check_response(input string name, input response_t expected,
		input response_t actual, inout int error_count);
		if (expected.valid ? (actual !== expected) : (actual.valid !== 1'b0)) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_count(input string name, input count_t expected,
		input count_t actual, inout int error_count);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic load_row(input int index, input string name, input row_t row);
		rows[index]  = row;
		names[index] = name;
	endtask

	task automatic wait_drained();
		@(posedge clock);
		while (issued != created) begin
			@(posedge clock);
		end
	endtask

	//////////////////////////////
	// CU and bus side drivers
	//////////////////////////////

	always @(posedge clock) begin
		for (int i = 0; i < `NUM_CU; i++) begin
			// Ready seen last cycle, so this command is taken
			if (ready_seen[i]) begin
				void'(pending_q[i].pop_front());
				req_hold[i] = 1'b0;
				accepted++;
			end
			if (!req_hold[i] && pending_q[i].size() > 0) begin
				cmd_hold[i] = pending_q[i][0];
				expect_q[i].push_back(pending_q[i][0]);
				req_hold[i] = 1'b1;
			end
		end
		grant_pulse = bus_grant_enable && request_seen && !grant_pulse;
		request_read_command_cu_in <= req_hold;
		read_command_cu_in         <= cmd_hold;
		command_bus_grant          <= grant_pulse;
	end

	// Output sampling, command scoreboard and timeout
	always @(negedge clock) begin
		int cu;
		ready_seen   = ready_read_command_cu_out;
		request_seen = command_bus_request;
		cycle_count++;
		if (read_command_out.valid) begin
			cu = int'(read_command_out.cu_id);
			issued++;
			if (hold_active) begin
				$display("Command issued while the host was almost full");
				scoreboard_errors++;
			end
			if (expect_q[cu].size() == 0) begin
				$display("Command from CU %0d arrived with none outstanding", cu);
				scoreboard_errors++;
			end else begin
				check_command(current_test, expect_q[cu].pop_front(), read_command_out,
					scoreboard_errors);
			end
		end
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles", cycle_count);
			$display("Checks failed");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	initial begin
		row_t          row;
		read_command_t cmd;
		response_t     exp_resp;
		count_t        exp_vertex;
		count_t        exp_edge;
		int            total;
		int            accepted_start;
		logic          in_hold;
		enabled_in         = 1'b1;
		cu_configure       = '0;
		host_alfull        = 1'b0;
		read_response_in   = '0;
		vertex_count_cu_in = '{default: '0};
		edge_count_cu_in   = '{default: '0};
		accepted_start     = 0;
		in_hold            = 1'b0;

		// cycles, cfg, req, op, grant, alfull, response, vertex, edge, mask
		load_row(0, "idle_start", row_t'{8'd4, 64'd0, 4'b0000, op_read_vertex, 1'b0, 1'b0,
			no_response, 16'd0, 16'd0, 4'b0000});
		load_row(1, "config_three", row_t'{8'd6, 64'd3, 4'b0000, op_read_vertex, 1'b0, 1'b0,
			no_response, 16'd1, 16'd2, 4'b0111});
		load_row(2, "config_zero", row_t'{8'd6, 64'd0, 4'b0000, op_read_vertex, 1'b0, 1'b0,
			response_t'{1'b1, 2'd2, 8'h5a}, 16'd10, 16'd20, 4'b0111});
		load_row(3, "commands_all", row_t'{8'd16, 64'd0, 4'b1111, op_read_vertex, 1'b1, 1'b0,
			response_t'{1'b1, 2'd0, 8'h11}, 16'd100, 16'd7, 4'b0111});
		load_row(4, "commands_some", row_t'{8'd14, 64'd0, 4'b0101, op_read_edge, 1'b1, 1'b0,
			response_t'{1'b1, 2'd3, 8'hc3}, 16'hfff0, 16'h0100, 4'b0111});
		load_row(5, "host_hold", row_t'{8'd12, 64'd0, 4'b1111, op_read_prefetch, 1'b1, 1'b1,
			response_t'{1'b1, 2'd1, 8'h3c}, 16'd5, 16'd5, 4'b0111});
		load_row(6, "host_hold_more", row_t'{8'd12, 64'd0, 4'b1111, op_read_vertex, 1'b1, 1'b1,
			no_response, 16'd0, 16'd0, 4'b0111});
		load_row(7, "release_drain", row_t'{8'd30, 64'd0, 4'b0010, op_read_edge, 1'b1, 1'b0,
			response_t'{1'b1, 2'd2, 8'h77}, 16'd3, 16'd9, 4'b0111});

		total = 0;
		for (int r = 0; r < num_rows; r++) begin
			total += int'(rows[r].cycles);
		end
		cycle_limit = 2 * total + 50;

		wait (rstn === 1'b1);
		@(negedge clock);
		check_mask("after_reset", '0, enable_cu_out, check_errors);
		check_mask("after_reset", '0, ready_read_command_cu_out, check_errors);
		if (command_bus_request || read_command_out.valid) begin
			$display("Bus request or command valid active after reset");
			check_errors++;
		end
		for (int k = 0; k < `NUM_CU; k++) begin
			check_response("after_reset", no_response, read_response_cu_out[k], check_errors);
		end
		check_count("after_reset", '0, vertex_done_out, check_errors);
		check_count("after_reset", '0, edge_done_out, check_errors);

		for (int r = 0; r < num_rows; r++) begin
			row = rows[r];
			@(negedge clock);
			// Empty buffer before a hold, so the acceptance limit is exact
			if (row.alfull && !in_hold) begin
				wait_drained();
				@(negedge clock);
				accepted_start = accepted;
			end
			if (!row.alfull && in_hold
					&& (accepted - accepted_start > `CMD_BUFFER_DEPTH - `CMD_BUFFER_MARGIN)) begin
				$display("Buffer took %0d commands without grants", accepted - accepted_start);
				check_errors++;
			end
			in_hold          = row.alfull;
			bus_grant_enable = row.grant_en;
			for (int i = 0; i < `NUM_CU; i++) begin
				if (row.req[i]) begin
					cmd.valid   = 1'b1;
					cmd.op      = row.op;
					cmd.cu_id   = `CU_ID_BITS'(i);
					cmd.address = $random(seed);
					pending_q[i].push_back(cmd);
					created++;
				end
			end
			exp_vertex = '0;
			exp_edge   = '0;

			@(posedge clock);
			cu_configure     <= row.cfg;
			host_alfull      <= row.alfull;
			read_response_in <= row.resp;
			for (int i = 0; i < `NUM_CU; i++) begin
				vertex_count_cu_in[i] <= row.vertex_base + count_t'(i);
				edge_count_cu_in[i]   <= row.edge_base + count_t'(3 * i);
				exp_vertex += row.vertex_base + count_t'(i);
				exp_edge   += row.edge_base + count_t'(3 * i);
			end
			hold_active  = row.alfull;
			current_test = names[r];
			@(posedge clock);
			cu_configure     <= '0;
			read_response_in <= '0;

			// Two cycles after the row was applied
			@(negedge clock);
			@(negedge clock);
			check_mask(names[r], row.exp_mask, enable_cu_out, check_errors);
			check_count(names[r], exp_vertex, vertex_done_out, check_errors);
			check_count(names[r], exp_edge, edge_done_out, check_errors);
			for (int k = 0; k < `NUM_CU; k++) begin
				exp_resp = (row.resp.valid && int'(row.resp.cu_id) == k) ? row.resp : no_response;
				check_response(names[r], exp_resp, read_response_cu_out[k], check_errors);
			end
			if (row.alfull && command_bus_request) begin
				$display("Bus request high in %s while the host is almost full", names[r]);
				check_errors++;
			end
			repeat (int'(row.cycles) - 3) @(negedge clock);
		end

		wait_drained();
		$display("Errors: %0d checks, %0d scoreboard; commands issued %0d of %0d",
			check_errors, scoreboard_errors, issued, created);
		if (check_errors == 0 && scoreboard_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
